// File: rtl/mf2_pkg.sv
package mf2_pkg;

	////////////////////
	// Bus types

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [12:0] mf2_addr_t;	// 8 KB RAM

	localparam int unsigned MF2_RAM_WORDS = 8192;

	// Enable port, bit 1 of the address turns it into disable
	localparam cpu_addr_t MF2_CTRL_PORT_BASE = 16'hFEE8;

	localparam cpu_addr_t  MF2_NMI_VECTOR  = 16'h0066;
	localparam cpu_addr_t  MF2_HIDE_VECTOR = 16'h0065;
	localparam logic [2:0] MF2_ROM_WINDOW  = 3'd0;	// 0x0000-0x1FFF
	localparam logic [2:0] MF2_RAM_WINDOW  = 3'd1;	// 0x2000-0x3FFF

	////////////////////
	// Shadow locations in Multiface RAM

	localparam mf2_addr_t SHADOW_PEN_INDEX = 13'h1FCF;
	localparam mf2_addr_t SHADOW_BORDER    = 13'h1FDF;
	localparam mf2_addr_t SHADOW_PEN_BASE  = 13'h1F90;	// 16 pens
	localparam mf2_addr_t SHADOW_MODE      = 13'h1FEF;
	localparam mf2_addr_t SHADOW_BANKING   = 13'h1FFF;
	localparam mf2_addr_t SHADOW_CRTC_SEL  = 13'h1CFF;
	localparam mf2_addr_t SHADOW_CRTC_BASE = 13'h1DB0;	// 16 registers
	localparam mf2_addr_t SHADOW_PPI       = 13'h17FF;
	localparam mf2_addr_t SHADOW_UPPER_ROM = 13'h1AAC;

	// Snooped I/O ports, high address byte
	localparam logic [7:0] PORT_GA        = 8'h7F;
	localparam logic [7:0] PORT_CRTC_SEL  = 8'hBC;
	localparam logic [7:0] PORT_CRTC_DATA = 8'hBD;
	localparam logic [7:0] PORT_PPI       = 8'hF7;
	localparam logic [7:0] PORT_ROM_SEL   = 8'hDF;

	typedef enum logic [1:0] {
		MF2_ENABLED      = 2'd0,
		MF2_HIDDEN       = 2'd1,
		MF2_DISABLED     = 2'd2,
		MF2_DISABLED_ALT = 2'd3
	} mf2_mode_e;

endpackage

// File: rtl/mf2_store_if.sv
`timescale 1ns/1ps

interface mf2_store_if;
	import mf2_pkg::*;

	logic      ctrl_wr;	// Write to 0xFEE8/0xFEEA
	logic      ctrl_disable;
	logic      store_wr;	// Snooped register write
	mf2_addr_t store_addr;
	cpu_data_t store_data;

	modport source (
		output ctrl_wr,
		output ctrl_disable,
		output store_wr,
		output store_addr,
		output store_data
	);

	modport sink (
		input ctrl_wr,
		input ctrl_disable,
		input store_wr,
		input store_addr,
		input store_data
	);

endinterface

// File: rtl/mf2_io_snoop.sv
`timescale 1ns/1ps

module mf2_io_snoop (
	input  logic               clk_sys,
	input  logic               reset,
	input  mf2_pkg::cpu_addr_t cpu_addr,
	input  mf2_pkg::cpu_data_t cpu_dout,
	input  logic               io_wr,
	mf2_store_if.source        store
);
	import mf2_pkg::*;

	logic       io_wr_q;
	logic       wr_edge;
	logic       ctrl_hit;
	logic       store_hit;
	mf2_addr_t  store_loc;
	logic [7:0] port_hi;
	logic [4:0] pen_index;	// Last pen selected on the gate array
	logic [3:0] crtc_reg;	// Last CRTC register number

	assign port_hi = cpu_addr[15:8];
	assign wr_edge = io_wr & ~io_wr_q;

	// 0xFEE8 and 0xFEEA share one decode
	assign ctrl_hit = (cpu_addr[15:2] == MF2_CTRL_PORT_BASE[15:2]);

	////////////////////
	// Shadow address decode

	always_comb begin
		store_hit = 1'b1;
		store_loc = '0;
		case (port_hi)
			PORT_GA: begin
				// Gate array function in data bits 7:6
				case (cpu_dout[7:6])
					2'b00: store_loc = SHADOW_PEN_INDEX;
					2'b01: begin
						if (pen_index[4])
							store_loc = SHADOW_BORDER;
						else
							store_loc = SHADOW_PEN_BASE + mf2_addr_t'(pen_index[3:0]);
					end
					2'b10: store_loc = SHADOW_MODE;	// Screen mode and ROM enables
					default: store_loc = SHADOW_BANKING;
				endcase
			end
			PORT_CRTC_SEL: store_loc = SHADOW_CRTC_SEL;
			PORT_CRTC_DATA: store_loc = SHADOW_CRTC_BASE + mf2_addr_t'(crtc_reg);
			PORT_PPI: store_loc = SHADOW_PPI;
			PORT_ROM_SEL: store_loc = SHADOW_UPPER_ROM;
			default: store_hit = 1'b0;	// Not a tracked port
		endcase
	end

	////////////////////
	// Edge detect and event strobes

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q        <= 1'b0;
			store.ctrl_wr  <= 1'b0;
			store.store_wr <= 1'b0;
			pen_index      <= '0;
			crtc_reg       <= '0;
		end else begin
			io_wr_q        <= io_wr;
			store.ctrl_wr  <= wr_edge & ctrl_hit;
			// Control port has priority over a store
			store.store_wr <= wr_edge & ~ctrl_hit & store_hit;

			if (wr_edge && !ctrl_hit) begin
				if (port_hi == PORT_GA && cpu_dout[7:6] == 2'b00)
					pen_index <= cpu_dout[4:0];
				if (port_hi == PORT_CRTC_SEL)
					crtc_reg <= cpu_dout[3:0];
			end
		end
	end

	// Event payload, valid alongside the strobes
	always_ff @(posedge clk_sys) begin
		if (wr_edge) begin
			store.ctrl_disable <= cpu_addr[1];	// 0xFEEA
			store.store_addr   <= store_loc;
			store.store_data   <= cpu_dout;
		end
	end

endmodule

// File: rtl/mf2_control.sv
`timescale 1ns/1ps

module mf2_control (
	input  logic               clk_sys,
	input  logic               reset,
	input  mf2_pkg::mf2_mode_e mf2_mode,
	input  logic               key_nmi,
	input  logic               m1,
	input  mf2_pkg::cpu_addr_t cpu_addr,
	mf2_store_if.sink          store,
	output logic               nmi,
	output logic               rom_sel,
	output logic               ram_sel
);
	import mf2_pkg::*;

	logic en;	// Multiface paged in
	logic hidden;	// Control port can no longer page it in
	logic key_q;
	logic key_qq;
	logic m1_q;
	logic m1_qq;
	logic nmi_vec_q;
	logic hide_vec_q;
	logic key_rise;
	logic m1_rise;
	logic mode_disabled;

	assign key_rise = key_q & ~key_qq;
	assign m1_rise  = m1_q & ~m1_qq;

	assign mode_disabled = (mf2_mode == MF2_DISABLED) || (mf2_mode == MF2_DISABLED_ALT);

	////////////////////
	// NMI and paging state

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_q      <= 1'b0;
			key_qq     <= 1'b0;
			m1_q       <= 1'b0;
			m1_qq      <= 1'b0;
			nmi_vec_q  <= 1'b0;
			hide_vec_q <= 1'b0;
			en         <= 1'b0;
			nmi        <= 1'b0;
			hidden     <= (mf2_mode != MF2_ENABLED);
		end else begin
			key_q      <= key_nmi;
			key_qq     <= key_q;
			m1_q       <= m1;
			m1_qq      <= m1_q;
			// Trap address sampled alongside M1
			nmi_vec_q  <= (cpu_addr == MF2_NMI_VECTOR);
			hide_vec_q <= (cpu_addr == MF2_HIDE_VECTOR);

			if (key_rise && !en && !mode_disabled)
				nmi <= 1'b1;

			// Fetch of the NMI vector pages the Multiface in
			if (m1_rise && nmi_vec_q && nmi) begin
				en     <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end

			if (m1_rise && hide_vec_q && en)
				hidden <= 1'b1;

			// Port write last, so it wins over an M1 trap
			if (store.ctrl_wr)
				en <= ~store.ctrl_disable & ~hidden;
		end
	end

	////////////////////
	// Window selects

	assign rom_sel = en && (cpu_addr[15:13] == MF2_ROM_WINDOW);
	assign ram_sel = en && (cpu_addr[15:13] == MF2_RAM_WINDOW);

endmodule

// File: rtl/mf2_ram_port.sv
`timescale 1ns/1ps

module mf2_ram_port (
	input  logic               clk_sys,
	input  mf2_pkg::cpu_addr_t cpu_addr,
	input  mf2_pkg::cpu_data_t cpu_dout,
	input  logic               mem_rd,
	input  logic               mem_wr,
	input  logic               ram_sel,
	mf2_store_if.sink          store,
	output mf2_pkg::cpu_data_t mf2_dout
);
	import mf2_pkg::*;

	cpu_data_t ram [MF2_RAM_WORDS];
	mf2_addr_t ram_addr;
	cpu_data_t ram_din;
	cpu_data_t ram_dout;
	logic      ram_we;

	////////////////////
	// Port arbitration

	always_ff @(posedge clk_sys) begin
		if (store.store_wr) begin	// Snooped register first
			ram_addr <= store.store_addr;
			ram_din  <= store.store_data;
			ram_we   <= 1'b1;
		end else if (mem_wr && ram_sel) begin
			ram_addr <= cpu_addr[12:0];
			ram_din  <= cpu_dout;
			ram_we   <= 1'b1;
		end else begin
			ram_addr <= cpu_addr[12:0];	// Idle cycles track the CPU for reads
			ram_we   <= 1'b0;
		end
	end

	// Array with write-through output register
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_addr] <= ram_din;
			ram_dout      <= ram_din;
		end else begin
			ram_dout <= ram[ram_addr];
		end
	end

	// All ones when not selected so the host can AND sources together
	assign mf2_dout = (mem_rd && ram_sel) ? ram_dout : 8'hFF;

endmodule

// File: rtl/mf2_top.sv
`timescale 1ns/1ps

module mf2_top (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [1:0]  mf2_mode,
	input  logic        key_nmi,
	input  logic        m1,
	input  logic        io_wr,
	input  logic        mem_rd,
	input  logic        mem_wr,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dout,
	output logic        nmi,
	output logic        rom_sel,
	output logic        ram_sel,
	output logic [7:0]  mf2_dout
);
	import mf2_pkg::*;

	// Snoop events to the controller and RAM port
	mf2_store_if store_bus ();

	////////////////////
	// I/O snooper

	mf2_io_snoop snoop0 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.io_wr    (io_wr),
		.store    (store_bus.source)
	);

	////////////////////
	// NMI and paging

	mf2_control control0 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mf2_mode (mf2_mode_e'(mf2_mode)),
		.key_nmi  (key_nmi),
		.m1       (m1),
		.cpu_addr (cpu_addr),
		.store    (store_bus.sink),
		.nmi      (nmi),
		.rom_sel  (rom_sel),
		.ram_sel  (ram_sel)	// Also steers the RAM port
	);

	////////////////////
	// Multiface RAM

	mf2_ram_port ram0 (
		.clk_sys  (clk_sys),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.mem_rd   (mem_rd),
		.mem_wr   (mem_wr),
		.ram_sel  (ram_sel),
		.store    (store_bus.sink),
		.mf2_dout (mf2_dout)
	);

endmodule

// File: include/mf2_ref_model.svh
`ifndef MF2_REF_MODEL_SVH
`define MF2_REF_MODEL_SVH

// Model state, in the order en, hidden, nmi
typedef struct packed {
	logic en;
	logic hidden;
	logic nmi;
} ref_state_t;

// Shadow location for a port write, given the tracked indices
function automatic mf2_pkg::mf2_addr_t ref_store_addr(logic [7:0] port_hi, logic [7:0] data,
		logic [4:0] pen_index, logic [3:0] crtc_reg);
	if (port_hi == mf2_pkg::PORT_GA) begin
		case (data[7:6])
			2'b00: return mf2_pkg::SHADOW_PEN_INDEX;
			2'b01: return pen_index[4] ? mf2_pkg::SHADOW_BORDER
				: mf2_pkg::SHADOW_PEN_BASE + 13'(pen_index[3:0]);
			2'b10: return mf2_pkg::SHADOW_MODE;
			default: return mf2_pkg::SHADOW_BANKING;
		endcase
	end
	if (port_hi == mf2_pkg::PORT_CRTC_SEL) return mf2_pkg::SHADOW_CRTC_SEL;
	if (port_hi == mf2_pkg::PORT_CRTC_DATA) return mf2_pkg::SHADOW_CRTC_BASE + 13'(crtc_reg);
	if (port_hi == mf2_pkg::PORT_PPI) return mf2_pkg::SHADOW_PPI;
	if (port_hi == mf2_pkg::PORT_ROM_SEL) return mf2_pkg::SHADOW_UPPER_ROM;
	return '0;	// No store
endfunction

function automatic logic ref_rom_sel(logic en, mf2_pkg::cpu_addr_t addr);
	return en && (addr[15:13] == mf2_pkg::MF2_ROM_WINDOW);
endfunction

function automatic logic ref_ram_sel(logic en, mf2_pkg::cpu_addr_t addr);
	return en && (addr[15:13] == mf2_pkg::MF2_RAM_WINDOW);
endfunction

function automatic ref_state_t ref_reset_state(logic [1:0] mode);
	ref_state_t s;
	s = '0;
	s.hidden = (mode != 2'd0);
	return s;
endfunction

// One update step, events applied in controller priority order
function automatic ref_state_t ref_next_state(ref_state_t cur, logic [1:0] mode, logic key_rise,
		logic m1_rise, mf2_pkg::cpu_addr_t addr, logic ctrl_wr, logic ctrl_disable);
	ref_state_t nxt;
	nxt = cur;
	if (key_rise && !cur.en && !mode[1]) nxt.nmi = 1'b1;
	if (m1_rise && cur.nmi && addr == mf2_pkg::MF2_NMI_VECTOR) begin
		nxt.en = 1'b1;
		nxt.hidden = 1'b0;
		nxt.nmi = 1'b0;
	end
	if (m1_rise && cur.en && addr == mf2_pkg::MF2_HIDE_VECTOR) nxt.hidden = 1'b1;
	if (ctrl_wr) nxt.en = !ctrl_disable && !cur.hidden;
	return nxt;
endfunction

`endif

// File: bench/tb_mf2_top.sv
`timescale 1ns/1ps

module tb_mf2_top;
	import mf2_pkg::*;

	`include "mf2_ref_model.svh"

	localparam int HOLD_CYCLES = 4;
	localparam int NMI_TIMEOUT = 20;	// Cycles
	localparam int DRIVE_DELAY = 1;	// ns after the rising edge

	logic        clk_sys;
	logic        reset;
	logic [1:0]  mf2_mode;
	logic        key_nmi;
	logic        m1;
	logic        io_wr;
	logic        mem_rd;
	logic        mem_wr;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        nmi;
	logic        rom_sel;
	logic        ram_sel;
	logic [7:0]  mf2_dout;

	integer      seed;
	logic [31:0] rnd;
	ref_state_t  model;	// Expected en, hidden, nmi
	logic [4:0]  pen_idx;
	logic [3:0]  crtc_idx;
	logic [15:0] addr;
	logic [7:0]  data;
	logic [7:0]  ppi_data;
	logic [15:0] wr_addr [8];
	logic [7:0]  wr_data [8];
	string       test_name;
	int          check_count = 0;
	int          error_count = 0;
	int          test_checks;
	int          test_errors;

	// Pending compares
	string       name_q[$];
	logic [7:0]  exp_q[$];
	logic [7:0]  act_q[$];

	mf2_top dut0 (.*);

	always #4 clk_sys = ~clk_sys;

	////////////////////
	// Checker

	always @(posedge clk_sys) begin
		string name;
		logic [7:0] exp_v;
		logic [7:0] act_v;
		while (name_q.size() > 0) begin
			name  = name_q.pop_front();
			exp_v = exp_q.pop_front();
			act_v = act_q.pop_front();
			check_count++;
			assert (act_v === exp_v)
			else begin
				$display("FAIL %s: expected 0x%02h, actual 0x%02h", name, exp_v, act_v);
				error_count++;
			end
		end
	end

	////////////////////
	// Bus tasks

	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	task automatic queue_check(input string what, input logic [7:0] exp_v,
			input logic [7:0] act_v);
		name_q.push_back({test_name, " ", what});
		exp_q.push_back(exp_v);
		act_q.push_back(act_v);
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_checks = check_count;
		test_errors = error_count;
	endtask

	task automatic end_test();
		next_cycle();	// Checker drains on this edge
		$display("Test %s done: %0d checks, %0d errors", test_name,
			check_count - test_checks, error_count - test_errors);
	endtask

	task automatic apply_reset(input logic [1:0] mode);
		next_cycle();
		reset    = 1'b1;
		mf2_mode = mode;
		repeat (4) @(posedge clk_sys);
		#DRIVE_DELAY;
		reset    = 1'b0;
		model    = ref_reset_state(mode);
		pen_idx  = '0;
		crtc_idx = '0;
	endtask

	// Drive an address and compare the selects mid-cycle
	task automatic probe_window(input logic [15:0] a);
		next_cycle();
		cpu_addr = a;
		@(negedge clk_sys);
		queue_check($sformatf("nmi @%04h", a), 8'(model.nmi), 8'(nmi));
		queue_check($sformatf("rom_sel @%04h", a), 8'(ref_rom_sel(model.en, a)),
			8'(rom_sel));
		queue_check($sformatf("ram_sel @%04h", a), 8'(ref_ram_sel(model.en, a)),
			8'(ram_sel));
	endtask

	task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
		next_cycle();
		cpu_addr = a;
		cpu_dout = d;
		mem_wr   = 1'b1;
		repeat (HOLD_CYCLES - 1) @(posedge clk_sys);
		next_cycle();
		mem_wr = 1'b0;
	endtask

	task automatic mem_read(input logic [15:0] a, input logic rd, output logic [7:0] d);
		next_cycle();
		cpu_addr = a;
		mem_rd   = rd;
		repeat (HOLD_CYCLES - 1) @(posedge clk_sys);
		@(negedge clk_sys);
		d = mf2_dout;	// Valid two edges after the address
		next_cycle();
		mem_rd = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		next_cycle();
		cpu_addr = a;
		cpu_dout = d;
		io_wr    = 1'b1;
		repeat (HOLD_CYCLES - 1) @(posedge clk_sys);
		next_cycle();
		io_wr = 1'b0;
		if (a[15:2] == MF2_CTRL_PORT_BASE[15:2])
			model = ref_next_state(model, mf2_mode, 1'b0, 1'b0, a, 1'b1, a[1]);
	endtask

	task automatic m1_fetch(input logic [15:0] a);
		next_cycle();
		cpu_addr = a;
		m1       = 1'b1;
		repeat (HOLD_CYCLES - 1) @(posedge clk_sys);
		next_cycle();
		m1    = 1'b0;
		model = ref_next_state(model, mf2_mode, 1'b0, 1'b1, a, 1'b0, 1'b0);
	endtask

	task automatic wait_for_nmi(input int max_cycles, output bit seen);
		int cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < max_cycles) begin
			@(negedge clk_sys);
			seen = nmi;
			cycles++;
		end
		if (!seen)
			$display("Timeout: nmi stayed low for %0d cycles after the key press", max_cycles);
	endtask

	task automatic press_nmi_key();
		bit seen;
		next_cycle();
		key_nmi = 1'b1;
		model   = ref_next_state(model, mf2_mode, 1'b1, 1'b0, cpu_addr, 1'b0, 1'b0);
		wait_for_nmi(NMI_TIMEOUT, seen);
		queue_check("nmi after key", 8'(model.nmi), 8'(nmi));
		next_cycle();
		key_nmi = 1'b0;
	endtask

	// Snooped write, then read the shadow copy back through the RAM window
	task automatic shadow_write(input logic [7:0] port_hi, input logic [7:0] d);
		mf2_addr_t  loc;
		logic [7:0] readback;
		loc = ref_store_addr(port_hi, d, pen_idx, crtc_idx);
		io_write({port_hi, 8'h00}, d);
		if (port_hi == PORT_GA && d[7:6] == 2'b00)
			pen_idx = d[4:0];
		if (port_hi == PORT_CRTC_SEL)
			crtc_idx = d[3:0];
		mem_read({MF2_RAM_WINDOW, loc}, 1'b1, readback);
		queue_check($sformatf("port %02h data %02h @%04h", port_hi, d, loc), d, readback);
	endtask

	////////////////////
	// Tests

	initial begin
		clk_sys   = 1'b0;
		reset     = 1'b1;
		mf2_mode  = 2'd0;
		key_nmi   = 1'b0;
		m1        = 1'b0;
		io_wr     = 1'b0;
		mem_rd    = 1'b0;
		mem_wr    = 1'b0;
		cpu_addr  = '0;
		cpu_dout  = '0;
		seed      = 87;
		test_name = "";
		apply_reset(2'd0);

		begin_test("reset");
		for (int i = 0; i < 6; i++) begin
			rnd  = $random(seed);
			addr = rnd[15:0];
			if (i < 3)
				addr[15:13] = 3'(i);	// ROM, RAM and an outside window
			probe_window(addr);
			mem_read(addr, 1'b1, data);
			queue_check($sformatf("dout @%04h", addr), 8'hFF, data);
		end
		end_test();

		begin_test("nmi_entry");
		press_nmi_key();
		m1_fetch(MF2_NMI_VECTOR);
		probe_window(16'h0000);
		probe_window(16'h1FFF);
		probe_window(16'h2000);
		probe_window(16'h3FFF);
		probe_window(16'h4000);
		probe_window(16'hFFFF);
		end_test();

		begin_test("ram");
		for (int i = 0; i < 8; i++) begin
			rnd        = $random(seed);
			wr_addr[i] = {MF2_RAM_WINDOW, i[2:0], rnd[9:0]};	// One per 1 KB block
			wr_data[i] = rnd[23:16];
			mem_write(wr_addr[i], wr_data[i]);
		end
		for (int i = 0; i < 8; i++) begin
			mem_read(wr_addr[i], 1'b1, data);
			queue_check($sformatf("read @%04h", wr_addr[i]), wr_data[i], data);
		end
		mem_read(wr_addr[0], 1'b0, data);
		queue_check("read with mem_rd low", 8'hFF, data);
		end_test();

		begin_test("shadow");
		rnd      = $random(seed);
		ppi_data = rnd[15:8];
		shadow_write(PORT_GA, 8'h05);	// Pen 5
		shadow_write(PORT_GA, {2'b01, rnd[5:0]});
		shadow_write(PORT_GA, 8'h10);	// Border
		shadow_write(PORT_GA, {2'b01, rnd[13:8]});
		shadow_write(PORT_CRTC_SEL, 8'h0C);
		shadow_write(PORT_CRTC_DATA, rnd[23:16]);
		shadow_write(PORT_GA, {2'b10, rnd[29:24]});	// Mode
		shadow_write(PORT_GA, {2'b11, rnd[5:0]});	// Banking
		shadow_write(PORT_PPI, ppi_data);
		shadow_write(PORT_ROM_SEL, rnd[31:24]);
		// Port F6 is not snooped
		io_write(16'hF600, ~ppi_data);
		mem_read({MF2_RAM_WINDOW, SHADOW_PPI}, 1'b1, data);
		queue_check("unmatched port F6", ppi_data, data);
		end_test();

		begin_test("hide_and_port");
		m1_fetch(MF2_HIDE_VECTOR);
		probe_window(16'h2000);
		io_write(16'hFEEA, 8'h00);
		probe_window(16'h2000);
		io_write(16'hFEE8, 8'h00);	// Hidden, stays paged out
		probe_window(16'h2000);
		probe_window(16'h0000);
		apply_reset(2'd2);
		probe_window(16'h2000);
		press_nmi_key();
		end_test();

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: mf2_top.f
+incdir+include
rtl/mf2_pkg.sv
rtl/mf2_store_if.sv
rtl/mf2_io_snoop.sv
rtl/mf2_control.sv
rtl/mf2_ram_port.sv
rtl/mf2_top.sv
bench/tb_mf2_top.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_mf2_top
FILELIST  := mf2_top.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the simulation prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^ALL CHECKS PASSED$$'

clean:
	rm -rf $(OBJ_DIR)
